/* hw/zap_mul_pkg.sv */
package zap_mul_pkg;

        // Steps of one multiply-accumulate, in execution order
        //   STEP_LOLO   : rm[lo] * rs[lo]
        //   STEP_LOHI   : rm[lo] * rs[hi], shifted up half a word
        //   STEP_HILO   : rm[hi] * rs[lo], shifted up half a word
        //   STEP_ADDEND : add rn
        // The hi * hi term lands entirely above the low word, so it is never formed
        typedef enum logic [1:0]
        {
                STEP_LOLO   = 2'd0,
                STEP_LOHI   = 2'd1,
                STEP_HILO   = 2'd2,
                STEP_ADDEND = 2'd3
        } mul_step_t;

        // Steps per operation
        localparam int STEP_COUNT = 4;

endpackage

/* hw/zap_mul_if.sv */
`timescale 1ns/100ps

interface zap_mul_if
#(
        parameter int WIDTH = 32
);

        // Control from the sequencer
        logic                     load;
        zap_mul_pkg::mul_step_t   step;
        logic                     step_valid;
        logic                     abort;

        // Aligned partial product for the current step
        logic [WIDTH-1:0]         product;

        modport sequencer
        (
                output load,
                output step,
                output step_valid,
                output abort
        );

        modport partial_product
        (
                input  load,
                input  step,
                output product
        );

        modport accumulator
        (
                input  load,
                input  step,
                input  step_valid,
                input  abort,
                input  product
        );

endinterface

/* hw/zap_mul_step_counter.sv */
`timescale 1ns/100ps

module zap_mul_step_counter
(
        input  logic                    i_clk,
        input  logic                    i_reset,

        input  logic                    i_restart,
        input  logic                    i_advance,

        output zap_mul_pkg::mul_step_t  o_step,
        output logic                    o_last
);

        zap_mul_pkg::mul_step_t step_q;

        // Restart wins over advance
        always_ff @(posedge i_clk)
        begin
                if (i_reset || i_restart)
                begin
                        step_q <= zap_mul_pkg::STEP_LOLO;
                end
                else if (i_advance)
                begin
                        step_q <= zap_mul_pkg::mul_step_t'(step_q + 2'd1);
                end
        end

        assign o_step = step_q;

        // Final step of the sequence
        assign o_last = (step_q == zap_mul_pkg::mul_step_t'(zap_mul_pkg::STEP_COUNT - 1));

endmodule

/* hw/zap_mul_sequencer.sv */
`timescale 1ns/100ps

module zap_mul_sequencer
(
        input  logic                    i_clk,
        input  logic                    i_reset,

        input  logic                    i_start,
        input  logic                    i_clear,

        // Step counter
        input  zap_mul_pkg::mul_step_t  i_step,
        input  logic                    i_last,
        output logic                    o_restart,
        output logic                    o_advance,

        output logic                    o_busy,
        output logic                    o_done,

        zap_mul_if.sequencer            ctl
);

        typedef enum logic [1:0]
        {
                ST_IDLE = 2'd0,
                ST_RUN  = 2'd1,
                ST_DONE = 2'd2
        } seq_state_t;

        seq_state_t state_q;
        seq_state_t state_d;
        logic       start_ok;
        logic       run_step;

        // Start only counts from idle, and never alongside a clear
        assign start_ok = (state_q == ST_IDLE) && i_start && !i_clear;

        // A step executes on every run cycle unless it is being aborted
        assign run_step = (state_q == ST_RUN) && !i_clear;

        always_comb
        begin
                state_d = state_q;

                if (i_clear)
                begin
                        state_d = ST_IDLE;
                end
                else
                begin
                        case (state_q)
                                ST_IDLE:
                                begin
                                        if (i_start)
                                        begin
                                                state_d = ST_RUN;
                                        end
                                end
                                ST_RUN:
                                begin
                                        if (i_last)
                                        begin
                                                state_d = ST_DONE;
                                        end
                                end
                                default:
                                begin
                                        // Done lasts one cycle
                                        state_d = ST_IDLE;
                                end
                        endcase
                end
        end

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        state_q <= ST_IDLE;
                end
                else
                begin
                        state_q <= state_d;
                end
        end

        assign o_restart      = start_ok || i_clear;
        assign o_advance      = run_step;
        assign o_busy         = (state_q == ST_RUN);
        assign o_done         = (state_q == ST_DONE);

        assign ctl.load       = start_ok;
        assign ctl.abort      = i_clear;
        assign ctl.step_valid = run_step;
        assign ctl.step       = i_step;

endmodule

/* hw/zap_mul_partial_product.sv */
`timescale 1ns/100ps

module zap_mul_partial_product
#(
        parameter int WIDTH = 32
)
(
        input  logic                    i_clk,
        input  logic                    i_reset,

        input  logic [WIDTH-1:0]        i_rm,
        input  logic [WIDTH-1:0]        i_rs,

        zap_mul_if.partial_product      pp
);

        localparam int HALF = WIDTH / 2;

        logic [WIDTH-1:0] rm_q;
        logic [WIDTH-1:0] rs_q;
        logic [HALF-1:0]  mul_a;
        logic [HALF-1:0]  mul_b;
        logic [WIDTH-1:0] mul_p;

        // Operands are held for the whole operation
        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        rm_q <= '0;
                        rs_q <= '0;
                end
                else if (pp.load)
                begin
                        rm_q <= i_rm;
                        rs_q <= i_rs;
                end
        end

        // Half selection feeding the one shared multiplier
        always_comb
        begin
                mul_a = rm_q[HALF-1:0];
                mul_b = rs_q[HALF-1:0];

                case (pp.step)
                        zap_mul_pkg::STEP_LOHI: mul_b = rs_q[WIDTH-1:HALF];
                        zap_mul_pkg::STEP_HILO: mul_a = rm_q[WIDTH-1:HALF];
                        default:                ;
                endcase
        end

        // Half by half always fits in a full word
        assign mul_p = mul_a * mul_b;

        always_comb
        begin
                case (pp.step)
                        zap_mul_pkg::STEP_LOLO:   pp.product = mul_p;
                        zap_mul_pkg::STEP_ADDEND: pp.product = '0;
                        // Cross terms, upper half of the product drops off the word
                        default:                  pp.product = mul_p << HALF;
                endcase
        end

endmodule

/* hw/zap_mul_accumulator.sv */
`timescale 1ns/100ps

module zap_mul_accumulator
#(
        parameter int WIDTH = 32
)
(
        input  logic                    i_clk,
        input  logic                    i_reset,

        input  logic [WIDTH-1:0]        i_rn,

        output logic [WIDTH-1:0]        o_rd,

        zap_mul_if.accumulator          acc
);

        logic [WIDTH-1:0] addend_q;
        logic [WIDTH-1:0] sum_q;
        logic [WIDTH-1:0] rd_q;
        logic [WIDTH-1:0] term;
        logic [WIDTH-1:0] sum_next;
        logic             last_step;

        assign last_step = (acc.step == zap_mul_pkg::STEP_ADDEND);

        // Addend goes in on the final step, products before it
        assign term     = last_step ? addend_q : acc.product;
        assign sum_next = sum_q + term;

        always_ff @(posedge i_clk)
        begin
                if (i_reset || acc.abort)
                begin
                        addend_q <= '0;
                        sum_q    <= '0;
                        rd_q     <= '0;
                end
                else if (acc.load)
                begin
                        addend_q <= i_rn;
                        sum_q    <= '0;
                end
                else if (acc.step_valid)
                begin
                        sum_q <= sum_next;
                        // Result moves only when an operation completes
                        if (last_step)
                        begin
                                rd_q <= sum_next;
                        end
                end
        end

        assign o_rd = rd_q;

endmodule

/* hw/zap_mul_top.sv */
`timescale 1ns/100ps

module zap_mul_top
#(
        parameter int WIDTH = 32
)
(
        input  logic                    i_clk,
        input  logic                    i_reset,

        input  logic                    i_start,
        input  logic                    i_clear,

        // rd = rm * rs + rn, low word
        input  logic [WIDTH-1:0]        i_rm,
        input  logic [WIDTH-1:0]        i_rs,
        input  logic [WIDTH-1:0]        i_rn,

        output logic [WIDTH-1:0]        o_rd,
        output logic                    o_busy,
        output logic                    o_done
);

        zap_mul_pkg::mul_step_t step;
        logic                   last;
        logic                   restart;
        logic                   advance;

        zap_mul_if #(.WIDTH(WIDTH)) u_bus ();

        zap_mul_step_counter u_step_counter
        (
                .i_clk          (i_clk),
                .i_reset        (i_reset),
                .i_restart      (restart),
                .i_advance      (advance),
                .o_step         (step),
                .o_last         (last)
        );

        zap_mul_sequencer u_sequencer
        (
                .i_clk          (i_clk),
                .i_reset        (i_reset),
                .i_start        (i_start),
                .i_clear        (i_clear),
                .i_step         (step),
                .i_last         (last),
                .o_restart      (restart),
                .o_advance      (advance),
                .o_busy         (o_busy),
                .o_done         (o_done),
                .ctl            (u_bus.sequencer)
        );

        zap_mul_partial_product #(.WIDTH(WIDTH)) u_partial_product
        (
                .i_clk          (i_clk),
                .i_reset        (i_reset),
                .i_rm           (i_rm),
                .i_rs           (i_rs),
                .pp             (u_bus.partial_product)
        );

        zap_mul_accumulator #(.WIDTH(WIDTH)) u_accumulator
        (
                .i_clk          (i_clk),
                .i_reset        (i_reset),
                .i_rn           (i_rn),
                .o_rd           (o_rd),
                .acc            (u_bus.accumulator)
        );

endmodule

/* verification/zap_mul_tb_tasks.svh */
`ifndef ZAP_MUL_TB_TASKS_SVH
`define ZAP_MUL_TB_TASKS_SVH

// Galois LFSR over x^32 + x^22 + x^2 + x + 1, shifting right
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
endfunction

// One LFSR step per bit taken
function logic [31:0] random_word();
        logic [31:0] word;
        word = '0;
        for (int i = 0; i < 32; i++)
        begin
                lfsr_state = lfsr_next(lfsr_state);
                word       = {word[30:0], lfsr_state[0]};
        end
        return word;
endfunction

// Low word of rm * rs + rn
function automatic logic [WIDTH-1:0] model_mac(input logic [WIDTH-1:0] rm, rs, rn);
        logic [2*WIDTH-1:0] full;
        full = {{WIDTH{1'b0}}, rm} * {{WIDTH{1'b0}}, rs};
        return full[WIDTH-1:0] + rn;
endfunction

task automatic check_word(input logic [WIDTH-1:0] got, exp, input string what);
        if (got !== exp)
        begin
                $display("Mismatch at %0t: %s, got %h expected %h", $time, what, got, exp);
                mismatch_count++;
        end
endtask

task automatic check_bit(input logic got, exp, input string what);
        if (got !== exp)
        begin
                $display("Mismatch at %0t: %s, got %b expected %b", $time, what, got, exp);
                mismatch_count++;
        end
endtask

// Start is seen by the DUT on the second rising edge
task automatic issue_start(input logic [WIDTH-1:0] rm, rs, rn);
        @(posedge i_clk);
        i_rm    <= rm;
        i_rs    <= rs;
        i_rn    <= rn;
        i_start <= 1'b1;
        @(posedge i_clk);
        i_start <= 1'b0;
endtask

// Falling edges until done shows, bounded by DONE_LIMIT
task automatic wait_done(input string what);
        int cycles;
        cycles = 1;
        @(negedge i_clk);
        while (!o_done && cycles < DONE_LIMIT)
        begin
                @(negedge i_clk);
                cycles++;
        end
        if (!o_done)
        begin
                $display("Error at %0t: %s never raised done", $time, what);
                missing_count++;
        end
endtask

task automatic run_op(input logic [WIDTH-1:0] rm, rs, rn, input string what);
        issue_start(rm, rs, rn);
        wait_done(what);
        check_word(o_rd, model_mac(rm, rs, rn), what);
endtask

`endif

/* verification/zap_mul_tb.sv */
`timescale 1ns/100ps

module zap_mul_tb;

        localparam int WIDTH        = 32;
        localparam int CLK_PERIOD   = 8;
        localparam int RESET_CYCLES = 16;
        localparam int N_DIRECTED   = 10;
        localparam int N_RANDOM     = 200;
        // Operations outside the directed and random sets
        localparam int N_EXTRA      = 5;
        localparam int NUM_OPS      = N_DIRECTED + N_RANDOM + N_EXTRA;
        localparam int OP_CYCLES    = 10;
        localparam int DONE_LIMIT   = zap_mul_pkg::STEP_COUNT + 4;

        logic             i_clk = 1'b0;
        logic             i_reset;
        logic             i_start;
        logic             i_clear;
        logic [WIDTH-1:0] i_rm;
        logic [WIDTH-1:0] i_rs;
        logic [WIDTH-1:0] i_rn;
        logic [WIDTH-1:0] o_rd;
        logic             o_busy;
        logic             o_done;

        int               mismatch_count = 0;
        int               missing_count  = 0;
        logic [31:0]      lfsr_state     = 32'ha0a0_5f27;

        always #(CLK_PERIOD / 2) i_clk = ~i_clk;

        zap_mul_top #(.WIDTH(WIDTH)) u_dut
        (
                .i_clk          (i_clk),
                .i_reset        (i_reset),
                .i_start        (i_start),
                .i_clear        (i_clear),
                .i_rm           (i_rm),
                .i_rs           (i_rs),
                .i_rn           (i_rn),
                .o_rd           (o_rd),
                .o_busy         (o_busy),
                .o_done         (o_done)
        );

        `include "zap_mul_tb_tasks.svh"

        task automatic reset_test();
                @(negedge i_clk);
                check_bit(o_busy, 1'b0, "busy after reset");
                check_bit(o_done, 1'b0, "done after reset");
                check_word(o_rd, '0, "result after reset");
        endtask

        task automatic directed_test();
                run_op(32'h0000_0000, 32'h1234_5678, 32'hdead_beef, "zero times value");
                run_op(32'h0000_0000, 32'h0000_0000, 32'h0000_0000, "all zero");
                run_op(32'h0000_0001, 32'h89ab_cdef, 32'h0000_0001, "one times value");
                run_op(32'h0000_0001, 32'h0000_0001, 32'h0000_0000, "one times one");
                run_op(32'hffff_ffff, 32'hffff_ffff, 32'hffff_ffff, "all ones");
                run_op(32'hffff_ffff, 32'h0000_0001, 32'h0000_0001, "all ones wraps to zero");
                run_op(32'h0001_0000, 32'h0001_0000, 32'h0000_0005, "product of two to the 32");
                run_op(32'h8000_0001, 32'h7fff_ffff, 32'h1234_0000, "overflowing product");
                // Only the high halves are set so the low word of the product is zero
                run_op(32'habcd_0000, 32'h1234_0000, 32'h5555_aaaa, "high halves only");
                run_op(32'hffff_0000, 32'hffff_0000, 32'h0000_0000, "high halves all ones");
        endtask

        task automatic random_test();
                logic [WIDTH-1:0] rm;
                logic [WIDTH-1:0] rs;
                logic [WIDTH-1:0] rn;
                for (int n = 0; n < N_RANDOM; n++)
                begin
                        rm = random_word();
                        rs = random_word();
                        rn = random_word();
                        run_op(rm, rs, rn, $sformatf("random set %0d", n));
                end
        endtask

        // Busy lasts the step cycles and done follows once
        task automatic timing_test();
                logic [WIDTH-1:0] expect_rd;
                logic [WIDTH-1:0] expect_next;
                expect_rd = model_mac(32'h0bad_cafe, 32'h0000_7531, 32'h0000_0042);
                issue_start(32'h0bad_cafe, 32'h0000_7531, 32'h0000_0042);
                repeat (zap_mul_pkg::STEP_COUNT)
                begin
                        @(negedge i_clk);
                        check_bit(o_busy, 1'b1, "busy during steps");
                        check_bit(o_done, 1'b0, "done during steps");
                end
                @(negedge i_clk);
                check_bit(o_busy, 1'b0, "busy at done");
                check_bit(o_done, 1'b1, "done after last step");
                check_word(o_rd, expect_rd, "timed result");
                repeat (4)
                begin
                        @(posedge i_clk);
                        i_rm <= random_word();
                        i_rs <= random_word();
                        i_rn <= random_word();
                        @(negedge i_clk);
                        check_bit(o_done, 1'b0, "done after its pulse");
                        check_word(o_rd, expect_rd, "held result");
                end
                // The next operation leaves the held result alone until it finishes
                expect_next = model_mac(32'h0000_0003, 32'hffff_0005, 32'h0000_0007);
                issue_start(32'h0000_0003, 32'hffff_0005, 32'h0000_0007);
                repeat (zap_mul_pkg::STEP_COUNT)
                begin
                        @(negedge i_clk);
                        check_word(o_rd, expect_rd, "result held while the next runs");
                end
                @(negedge i_clk);
                check_bit(o_done, 1'b1, "done of the next operation");
                check_word(o_rd, expect_next, "next timed result");
        endtask

        task automatic ignore_start_test();
                logic [WIDTH-1:0] expect_rd;
                expect_rd = model_mac(32'h0000_1111, 32'h0000_2222, 32'h0000_3333);
                issue_start(32'h0000_1111, 32'h0000_2222, 32'h0000_3333);
                // Second request arrives while the first one runs
                @(posedge i_clk);
                i_rm    <= 32'h7777_7777;
                i_rs    <= 32'h9999_9999;
                i_rn    <= 32'h5555_5555;
                i_start <= 1'b1;
                @(posedge i_clk);
                i_start <= 1'b0;
                wait_done("first of two requests");
                check_word(o_rd, expect_rd, "result after ignored start");
                repeat (6)
                begin
                        @(negedge i_clk);
                        check_bit(o_done, 1'b0, "second done pulse");
                        check_bit(o_busy, 1'b0, "busy from ignored start");
                end
        endtask

        task automatic clear_test();
                issue_start(32'h0102_0304, 32'h0506_0708, 32'h0909_0909);
                @(posedge i_clk);
                i_clear <= 1'b1;
                @(posedge i_clk);
                i_clear <= 1'b0;
                @(negedge i_clk);
                check_bit(o_busy, 1'b0, "busy after clear");
                check_word(o_rd, '0, "result after clear");
                repeat (6)
                begin
                        @(negedge i_clk);
                        check_bit(o_done, 1'b0, "done after clear");
                end
                run_op(32'h0000_abcd, 32'h0000_1234, 32'h1000_0000, "operation after clear");
        endtask

        initial
        begin : watchdog
                #((NUM_OPS * OP_CYCLES + RESET_CYCLES) * CLK_PERIOD);
                $display("Watchdog expired at %0t before the test sequence finished", $time);
                $display("Test failures found");
                $finish;
        end

        initial
        begin
                i_reset <= 1'b1;
                i_start <= 1'b0;
                i_clear <= 1'b0;
                i_rm    <= '0;
                i_rs    <= '0;
                i_rn    <= '0;
                repeat (RESET_CYCLES) @(posedge i_clk);
                i_reset <= 1'b0;

                reset_test();
                directed_test();
                random_test();
                timing_test();
                ignore_start_test();
                clear_test();

                $display("Errors: %0d mismatches, %0d missing done pulses",
                         mismatch_count, missing_count);
                if (mismatch_count == 0 && missing_count == 0)
                begin
                        $display("All tests passed!");
                end
                else
                begin
                        $display("Test failures found");
                end
                $finish;
        end

endmodule

/* zap_mul.f */
+incdir+verification
hw/zap_mul_pkg.sv
hw/zap_mul_if.sv
hw/zap_mul_step_counter.sv
hw/zap_mul_sequencer.sv
hw/zap_mul_partial_product.sv
hw/zap_mul_accumulator.sv
hw/zap_mul_top.sv
verification/zap_mul_tb.sv
